/* common/centipede_io_pkg.sv */
// **********************************************************************
// centipede io package
// address map, bus widths and the decoded region type shared by the
// player input, option switch and output latch blocks
// **********************************************************************

package centipede_io_pkg;

   // processor side bus
   localparam int ADDR_W = 14;
   localparam int DATA_W = 8;

   // mini-trackball
   localparam int TB_COUNT_W = 4;
   // axis 0 is horizontal, axis 1 is vertical
   localparam int NUM_AXES = 2;

   // the region is picked by the 1 KB block number in address bits 13..10
   localparam int BLOCK_LSB = 10;
   localparam int BLOCK_W = ADDR_W - BLOCK_LSB;

   // region base addresses
   localparam logic [ADDR_W-1:0] SWITCH_BASE = 14'h0800;
   localparam logic [ADDR_W-1:0] INPUT_BASE = 14'h0C00;
   localparam logic [ADDR_W-1:0] OUTLATCH_BASE = 14'h1C00;
   localparam logic [ADDR_W-1:0] STEERCLR_BASE = 14'h2400;

   // option switches and player inputs are read only,
   // the output latch and steering clear are write only
   typedef enum logic [2:0]
   {
      REG_NONE = 3'd0,
      REG_SWITCH = 3'd1,
      REG_INPUT = 3'd2,
      REG_OUTLATCH = 3'd3,
      REG_STEERCLR = 3'd4
   } io_region_e;

   typedef logic [TB_COUNT_W-1:0] tb_count_t;
   typedef logic [DATA_W-1:0] io_byte_t;

endpackage

/* source/io_addr_decode.sv */
// **********************************************************************
// io address decoder
// maps the APB address onto the io regions and qualifies it with the
// bus phase to form the write strobes and the slave error
// **********************************************************************

`timescale 1ns/1ns

module io_addr_decode
   import centipede_io_pkg::*;
(
   input logic [ADDR_W-1:0] paddr_i,
   input logic psel_i,
   input logic penable_i,
   input logic pwrite_i,
   output io_region_e rd_region_o,
   output logic steer_clr_o,
   output logic latch_we_o,
   output logic pslverr_o
);

   logic [BLOCK_W-1:0] block;
   io_region_e region;
   logic access;
   logic read_only;
   logic write_only;
   logic bad_access;

   assign block = paddr_i[ADDR_W-1:BLOCK_LSB];

   // one decoded region per 1 KB block
   always_comb
   begin
      case (block)
         SWITCH_BASE[ADDR_W-1:BLOCK_LSB]: region = REG_SWITCH;
         INPUT_BASE[ADDR_W-1:BLOCK_LSB]: region = REG_INPUT;
         OUTLATCH_BASE[ADDR_W-1:BLOCK_LSB]: region = REG_OUTLATCH;
         STEERCLR_BASE[ADDR_W-1:BLOCK_LSB]: region = REG_STEERCLR;
         default: region = REG_NONE;
      endcase
   end

   assign rd_region_o = region;

   // access phase of a zero wait state transfer
   assign access = psel_i & penable_i;

   assign read_only = (region == REG_SWITCH) || (region == REG_INPUT);
   assign write_only = (region == REG_OUTLATCH) || (region == REG_STEERCLR);

   // unmapped block or wrong direction for the region
   assign bad_access = (region == REG_NONE) ||
                       (!pwrite_i && write_only) ||
                       (pwrite_i && read_only);

   assign pslverr_o = access & bad_access;

   // write strobes only ever fire for a valid write
   assign steer_clr_o = access & pwrite_i & (region == REG_STEERCLR);
   assign latch_we_o = access & pwrite_i & (region == REG_OUTLATCH);

endmodule

/* trakball/trakball_input_select.sv */
// **********************************************************************
// trackball input select
// synchronises the eight trackball lines, picks one player by the flip
// bit and turns each selected clock edge into a single step pulse
// **********************************************************************

`timescale 1ns/1ns

module trakball_input_select
   import centipede_io_pkg::*;
#(
   parameter int SYNC_STAGES = 2
)
(
   input logic s_6mhz,
   input logic reset,
   input logic [7:0] trakball_i,
   input logic flip_i,
   output logic [NUM_AXES-1:0] axis_step_o,
   output logic [NUM_AXES-1:0] axis_dir_o
);

   logic [7:0] sync_q [SYNC_STAGES];
   logic [7:0] tb_sync;
   logic [NUM_AXES-1:0] sel_ck;
   logic [NUM_AXES-1:0] sel_dir;
   logic [NUM_AXES-1:0] ck_q;

   // board edge lines are asynchronous to s_6mhz
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < SYNC_STAGES; i++)
            sync_q[i] <= '0;
      end
      else
      begin
         sync_q[0] <= trakball_i;
         for (int i = 1; i < SYNC_STAGES; i++)
            sync_q[i] <= sync_q[i-1];
      end
   end

   assign tb_sync = sync_q[SYNC_STAGES-1];

   // bit order: 7 p1 h dir, 6 p2 h dir, 5 p1 h ck, 4 p2 h ck,
   // 3 p1 v dir, 2 p2 v dir, 1 p1 v ck, 0 p2 v ck
   // flip high hands the trackball to player 1
   assign sel_dir = flip_i ? {tb_sync[3], tb_sync[7]} : {tb_sync[2], tb_sync[6]};
   assign sel_ck = flip_i ? {tb_sync[1], tb_sync[5]} : {tb_sync[0], tb_sync[4]};

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         ck_q <= '0;
      else
         ck_q <= sel_ck;
   end

   // rising edge of the selected clock line
   assign axis_step_o = sel_ck & ~ck_q;
   assign axis_dir_o = sel_dir;

endmodule

/* trakball/trakball_axis_counter.sv */
// **********************************************************************
// trackball axis counter
// 4-bit up/down position count for one axis plus its direction flag,
// cleared by a steering clear write
// **********************************************************************

`timescale 1ns/1ns

module trakball_axis_counter
   import centipede_io_pkg::*;
(
   input logic s_6mhz,
   input logic reset,
   input logic step_i,
   input logic dir_i,
   input logic clear_i,
   output tb_count_t count_o,
   output logic dir_o
);

   tb_count_t count_q;
   logic dir_q;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         count_q <= '0;
         dir_q <= 1'b0;
      end
      else if (clear_i)
      begin
         // clear beats a step in the same cycle, flag is kept
         count_q <= '0;
      end
      else if (step_i)
      begin
         dir_q <= dir_i;
         // wraps modulo 16 in both directions
         if (dir_i)
            count_q <= count_q + 1'b1;
         else
            count_q <= count_q - 1'b1;
      end
   end

   assign count_o = count_q;
   assign dir_o = dir_q;

endmodule

/* source/io_read_mux.sv */
// **********************************************************************
// io read multiplexer
// builds the read byte from the player buttons, joystick, option
// switches and the two trackball axes
// **********************************************************************

`timescale 1ns/1ns

module io_read_mux
   import centipede_io_pkg::*;
(
   input io_region_e rd_region_i,
   input logic [1:0] paddr_i,
   input logic [9:0] playerinput_i,
   input logic [7:0] joystick_i,
   input logic [7:0] sw1_i,
   input logic [7:0] sw2_i,
   input tb_count_t count_i [NUM_AXES],
   input logic [NUM_AXES-1:0] dir_i,
   output io_byte_t prdata_o
);

   io_byte_t in_byte0;
   io_byte_t in_byte1;
   io_byte_t in_byte2;
   io_byte_t input_byte;
   io_byte_t switch_byte;

   // horizontal axis with self-test and cocktail, vblank reads as zero
   assign in_byte0 = {dir_i[0], 1'b0, playerinput_i[6], playerinput_i[5], count_i[0]};

   // coin r, coin c, coin l, slam, fire2, fire1, start2, start1
   assign in_byte1 = {playerinput_i[9], playerinput_i[8], playerinput_i[7],
                      playerinput_i[4], playerinput_i[1], playerinput_i[0],
                      playerinput_i[3], playerinput_i[2]};

   // vertical axis
   assign in_byte2 = {dir_i[1], 3'b000, count_i[1]};

   always_comb
   begin
      case (paddr_i)
         2'd0: input_byte = in_byte0;
         2'd1: input_byte = in_byte1;
         2'd2: input_byte = in_byte2;
         default: input_byte = joystick_i;
      endcase
   end

   assign switch_byte = paddr_i[0] ? sw2_i : sw1_i;

   // write only and unmapped regions read back zero
   always_comb
   begin
      case (rd_region_i)
         REG_INPUT: prdata_o = input_byte;
         REG_SWITCH: prdata_o = switch_byte;
         default: prdata_o = '0;
      endcase
   end

endmodule

/* source/coin_led_latch.sv */
// **********************************************************************
// coin and led output latch
// 8-bit addressable latch holding flip, four leds and the coin counters
// **********************************************************************

`timescale 1ns/1ns

module coin_led_latch
(
   input logic s_6mhz,
   input logic reset,
   input logic we_i,
   input logic [2:0] bit_sel_i,
   input logic bit_i,
   output logic flip_o,
   output logic [3:0] led_o,
   output logic [2:0] coin_ctr_o
);

   logic [7:0] cc_latch;

   // one bit per write, picked by the low address bits
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         cc_latch <= '0;
      else if (we_i)
         cc_latch[bit_sel_i] <= bit_i;
   end

   // bit 7 flip, bits 6..3 led 4..1
   assign flip_o = cc_latch[7];
   assign led_o = cc_latch[6:3];
   // right, centre, left coin counters
   assign coin_ctr_o = cc_latch[2:0];

endmodule

/* source/centipede_io_top.sv */
// **********************************************************************
// centipede io top level
// APB view of the player inputs, option switches, mini-trackball
// counters and the coin/led output latch
// **********************************************************************

`timescale 1ns/1ns

module centipede_io_top
   import centipede_io_pkg::*;
#(
   parameter int SYNC_STAGES = 2
)
(
   input logic s_6mhz,
   input logic reset,
   input logic [ADDR_W-1:0] paddr_i,
   input logic psel_i,
   input logic penable_i,
   input logic pwrite_i,
   input logic [DATA_W-1:0] pwdata_i,
   output io_byte_t prdata_o,
   output logic pready_o,
   output logic pslverr_o,
   input logic [9:0] playerinput_i,
   input logic [7:0] joystick_i,
   input logic [7:0] sw1_i,
   input logic [7:0] sw2_i,
   input logic [7:0] trakball_i,
   output logic flip_o,
   output logic [3:0] led_o,
   output logic [2:0] coin_ctr_o
);

   io_region_e rd_region;
   logic steer_clr;
   logic latch_we;
   logic flip;
   logic [NUM_AXES-1:0] axis_step;
   logic [NUM_AXES-1:0] axis_dir;
   logic [NUM_AXES-1:0] count_dir;
   tb_count_t axis_count [NUM_AXES];

   // zero wait states
   assign pready_o = 1'b1;

   io_addr_decode u_decode
   (
      .paddr_i(paddr_i),
      .psel_i(psel_i),
      .penable_i(penable_i),
      .pwrite_i(pwrite_i),
      .rd_region_o(rd_region),
      .steer_clr_o(steer_clr),
      .latch_we_o(latch_we),
      .pslverr_o(pslverr_o)
   );

   trakball_input_select #(.SYNC_STAGES(SYNC_STAGES)) u_tb_select
   (
      .s_6mhz(s_6mhz),
      .reset(reset),
      .trakball_i(trakball_i),
      .flip_i(flip),
      .axis_step_o(axis_step),
      .axis_dir_o(axis_dir)
   );

   for (genvar a = 0; a < NUM_AXES; a++)
   begin : g_axis
      trakball_axis_counter u_axis
      (
         .s_6mhz(s_6mhz),
         .reset(reset),
         .step_i(axis_step[a]),
         .dir_i(axis_dir[a]),
         .clear_i(steer_clr),
         .count_o(axis_count[a]),
         .dir_o(count_dir[a])
      );
   end

   io_read_mux u_read_mux
   (
      .rd_region_i(rd_region),
      .paddr_i(paddr_i[1:0]),
      .playerinput_i(playerinput_i),
      .joystick_i(joystick_i),
      .sw1_i(sw1_i),
      .sw2_i(sw2_i),
      .count_i(axis_count),
      .dir_i(count_dir),
      .prdata_o(prdata_o)
   );

   // the data bit comes from bus bit 7
   coin_led_latch u_latch
   (
      .s_6mhz(s_6mhz),
      .reset(reset),
      .we_i(latch_we),
      .bit_sel_i(paddr_i[2:0]),
      .bit_i(pwdata_i[7]),
      .flip_o(flip),
      .led_o(led_o),
      .coin_ctr_o(coin_ctr_o)
   );

   assign flip_o = flip;

endmodule

/* tests/centipede_io_assertions.sv */
// **********************************************************************
// io decoder assertions
// bus phase checks on the write strobes
// **********************************************************************

`timescale 1ns/1ns

module centipede_io_assertions
(
   input logic clk_i,
   input logic reset_i,
   input logic pready_i,
   input logic psel_i,
   input logic penable_i,
   input logic pwrite_i,
   input logic steer_clr_i,
   input logic latch_we_i
);

   // zero wait state completer
   a_pready_high: assert property (@(posedge clk_i) disable iff (reset_i) pready_i)
      else $error("pready dropped low");

   a_one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
      !(steer_clr_i && latch_we_i))
      else $error("steering clear and latch write strobes high together");

   // strobes only fire in the access cycle that follows a write setup cycle
   a_strobe_access: assert property (@(posedge clk_i) disable iff (reset_i)
      (steer_clr_i || latch_we_i) |->
         (psel_i && penable_i && pwrite_i && $past(psel_i && !penable_i)))
      else $error("write strobe outside the access phase of a write");

endmodule

/* tests/centipede_io_tb.sv */
// **********************************************************************
// centipede io testbench
// random APB traffic, trackball pulse trains and latch writes checked
// against a reference model of the io section
// **********************************************************************

`timescale 1ns/1ns

module centipede_io_tb
   import centipede_io_pkg::*;
();

   localparam int SYNC_STAGES = 2;
   localparam int SLOT_CYCLES = 8;
   localparam int APB_TIMEOUT = 16;
   localparam int UNMAPPED [12] = '{0, 1, 4, 5, 6, 8, 10, 11, 12, 13, 14, 15};

   logic s_6mhz;
   logic reset;
   logic [ADDR_W-1:0] paddr;
   logic psel;
   logic penable;
   logic pwrite;
   io_byte_t pwdata;
   io_byte_t prdata;
   logic pready;
   logic pslverr;
   logic [9:0] playerinput;
   logic [7:0] joystick;
   logic [7:0] sw1;
   logic [7:0] sw2;
   logic [7:0] trakball;
   logic flip;
   logic [3:0] led;
   logic [2:0] coin_ctr;

   // reference model state
   io_byte_t m_latch;
   tb_count_t m_count [NUM_AXES];
   logic [NUM_AXES-1:0] m_dir;

   int checks;
   int errors;
   int timeouts;

   centipede_io_top #(.SYNC_STAGES(SYNC_STAGES)) UUT
   (
      .s_6mhz(s_6mhz),
      .reset(reset),
      .paddr_i(paddr),
      .psel_i(psel),
      .penable_i(penable),
      .pwrite_i(pwrite),
      .pwdata_i(pwdata),
      .prdata_o(prdata),
      .pready_o(pready),
      .pslverr_o(pslverr),
      .playerinput_i(playerinput),
      .joystick_i(joystick),
      .sw1_i(sw1),
      .sw2_i(sw2),
      .trakball_i(trakball),
      .flip_o(flip),
      .led_o(led),
      .coin_ctr_o(coin_ctr)
   );

   bind io_addr_decode centipede_io_assertions u_decode_assert
   (
      .clk_i(centipede_io_tb.s_6mhz),
      .reset_i(centipede_io_tb.reset),
      .pready_i(centipede_io_tb.UUT.pready_o),
      .psel_i(psel_i),
      .penable_i(penable_i),
      .pwrite_i(pwrite_i),
      .steer_clr_i(steer_clr_o),
      .latch_we_i(latch_we_o)
   );

   initial s_6mhz = 1'b0;
   always #50 s_6mhz = ~s_6mhz;

   task automatic check_byte(input string name, input io_byte_t expected, input io_byte_t actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s expected %02h got %02h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic check_count(input string name, input tb_count_t expected,
                              input tb_count_t actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s expected %0d got %0d",
                  $time, name, expected, actual);
      end
   endtask

   // random offset inside the 1 KB block with the low bits forced
   function automatic logic [ADDR_W-1:0] block_addr(input logic [ADDR_W-1:0] base,
                                                    input logic [2:0] low);
      logic [9:0] offset;
      offset = 10'($urandom);
      offset[2:0] = low;
      return base | {4'b0000, offset};
   endfunction

   // playerinput bit 9 is coin r, 8 coin c, 7 coin l, 6 self-test, 5 cocktail,
   // 4 slam, 3 start2, 2 start1, 1 fire2, 0 fire1
   function automatic io_byte_t expected_input(input logic [1:0] sel);
      case (sel)
         2'd0: return {m_dir[0], 1'b0, playerinput[6], playerinput[5], m_count[0]};
         2'd1: return {playerinput[9], playerinput[8], playerinput[7], playerinput[4],
                       playerinput[1], playerinput[0], playerinput[3], playerinput[2]};
         2'd2: return {m_dir[1], 3'b000, m_count[1]};
         default: return joystick;
      endcase
   endfunction

   // apply a change of the trackball lines to the model
   // trackball lines 7/6 h dir, 5/4 h clock, 3/2 v dir, 1/0 v clock, player 1 first
   function automatic void model_trak(input logic [7:0] old_lines, input logic [7:0] new_lines);
      logic [NUM_AXES-1:0] ck_old;
      logic [NUM_AXES-1:0] ck_new;
      logic [NUM_AXES-1:0] dir_new;
      if (m_latch[7])
      begin
         ck_old = {old_lines[1], old_lines[5]};
         ck_new = {new_lines[1], new_lines[5]};
         dir_new = {new_lines[3], new_lines[7]};
      end
      else
      begin
         ck_old = {old_lines[0], old_lines[4]};
         ck_new = {new_lines[0], new_lines[4]};
         dir_new = {new_lines[2], new_lines[6]};
      end
      for (int a = 0; a < NUM_AXES; a++)
      begin
         if (ck_new[a] && !ck_old[a])
         begin
            m_dir[a] = dir_new[a];
            if (dir_new[a])
               m_count[a] = m_count[a] + 1'b1;
            else
               m_count[a] = m_count[a] - 1'b1;
         end
      end
   endfunction

   task automatic apb_transfer(input logic [ADDR_W-1:0] addr, input logic write,
                               input io_byte_t wdata, output io_byte_t rdata, output logic err);
      int waited;
      @(negedge s_6mhz);
      paddr = addr;
      pwrite = write;
      pwdata = wdata;
      psel = 1'b1;
      penable = 1'b0;
      @(negedge s_6mhz);
      penable = 1'b1;
      #10;
      waited = 0;
      while (pready !== 1'b1 && waited < APB_TIMEOUT)
      begin
         @(negedge s_6mhz);
         #10;
         waited++;
      end
      if (pready !== 1'b1)
      begin
         timeouts++;
         $display("APB transfer to %04h got no pready within %0d cycles", addr, APB_TIMEOUT);
      end
      rdata = prdata;
      err = pslverr;
      // the transfer ends at the next rising edge
      @(negedge s_6mhz);
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic read_check(input logic [ADDR_W-1:0] addr, input io_byte_t expected,
                             input logic exp_err, input string name);
      io_byte_t rdata;
      logic err;
      apb_transfer(addr, 1'b0, 8'h00, rdata, err);
      check_byte(name, expected, rdata);
      check_byte("pslverr_o", io_byte_t'(exp_err), io_byte_t'(err));
   endtask

   task automatic write_check(input logic [ADDR_W-1:0] addr, input io_byte_t data,
                              input logic exp_err);
      io_byte_t rdata;
      logic err;
      apb_transfer(addr, 1'b1, data, rdata, err);
      check_byte("pslverr_o", io_byte_t'(exp_err), io_byte_t'(err));
   endtask

   task automatic check_outputs();
      check_byte("flip_o led_o coin_ctr_o", m_latch, {flip, led, coin_ctr});
   endtask

   task automatic check_axes();
      io_byte_t rdata;
      logic err;
      apb_transfer(block_addr(INPUT_BASE, 3'd0), 1'b0, 8'h00, rdata, err);
      check_count("horizontal count", m_count[0], rdata[3:0]);
      check_byte("prdata_o input byte 0", expected_input(2'd0), rdata);
      apb_transfer(block_addr(INPUT_BASE, 3'd2), 1'b0, 8'h00, rdata, err);
      check_count("vertical count", m_count[1], rdata[3:0]);
      check_byte("prdata_o input byte 2", expected_input(2'd2), rdata);
   endtask

   task automatic latch_write(input logic [2:0] bit_sel, input logic value);
      write_check(block_addr(OUTLATCH_BASE, bit_sel), {value, 7'($urandom)}, 1'b0);
      m_latch[bit_sel] = value;
      check_outputs();
   endtask

   task automatic randomize_inputs();
      @(negedge s_6mhz);
      playerinput = 10'($urandom);
      joystick = 8'($urandom);
      sw1 = 8'($urandom);
      sw2 = 8'($urandom);
   endtask

   // trackball lines hold each value for one slot
   task automatic trak_slot(input logic [7:0] lines);
      @(negedge s_6mhz);
      model_trak(trakball, lines);
      trakball = lines;
      repeat (SLOT_CYCLES - 1) @(negedge s_6mhz);
   endtask

   task automatic park_clocks();
      trak_slot(trakball & 8'hCC);
   endtask

   task automatic trak_train(input int slots, input logic fixed_dir,
                             input logic [7:0] ck_mask, input logic [7:0] dirs);
      logic [7:0] lines;
      logic toggle;
      toggle = 1'b0;
      for (int s = 0; s < slots; s++)
      begin
         toggle = ~toggle;
         if (fixed_dir)
            lines = (dirs & 8'hCC) | ({8{toggle}} & ck_mask);
         else
            lines = (8'($urandom) & 8'hCC) | (8'($urandom) & ck_mask);
         trak_slot(lines);
      end
   endtask

   initial
   begin
      logic [ADDR_W-1:0] addr;
      logic [2:0] low;
      int idx;

      reset = 1'b1;
      paddr = '0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      pwdata = '0;
      playerinput = '0;
      joystick = '0;
      sw1 = '0;
      sw2 = '0;
      trakball = '0;
      m_latch = '0;
      m_count = '{default: '0};
      m_dir = '0;
      checks = 0;
      errors = 0;
      timeouts = 0;
      void'($urandom(32'h09ac_a7e4));
      repeat (2) @(negedge s_6mhz);
      reset = 1'b0;

      // all outputs and counters start cleared
      check_outputs();
      check_axes();

      repeat (48)
      begin
         randomize_inputs();
         low = 3'($urandom);
         read_check(block_addr(INPUT_BASE, low), expected_input(low[1:0]), 1'b0,
                    "prdata_o input");
         low = 3'($urandom);
         read_check(block_addr(SWITCH_BASE, low), low[0] ? sw2 : sw1, 1'b0,
                    "prdata_o switch");
      end

      // twenty steps each way wrap past 15 and below 0
      trak_train(40, 1'b1, 8'h33, 8'hCC);
      check_axes();
      trak_train(40, 1'b1, 8'h33, 8'h00);
      check_axes();
      repeat (6)
      begin
         trak_train(24, 1'b0, 8'h33, 8'h00);
         check_axes();
      end

      write_check(block_addr(STEERCLR_BASE, 3'($urandom)), 8'($urandom), 1'b0);
      m_count = '{default: '0};
      check_axes();

      // only the player picked by flip moves the counters
      for (int f = 1; f >= 0; f--)
      begin
         park_clocks();
         latch_write(3'd7, f[0]);
         trak_train(12, 1'b0, (f != 0) ? 8'h11 : 8'h22, 8'h00);
         check_axes();
         trak_train(12, 1'b0, (f != 0) ? 8'h22 : 8'h11, 8'h00);
         check_axes();
      end

      park_clocks();
      repeat (32)
         latch_write(3'($urandom), 1'($urandom));

      // error responses leave every register alone
      repeat (12)
      begin
         idx = $urandom % 12;
         addr = block_addr(ADDR_W'(UNMAPPED[idx] << BLOCK_LSB), 3'($urandom));
         read_check(addr, 8'h00, 1'b1, "prdata_o unmapped");
         write_check(addr, 8'($urandom), 1'b1);
         read_check(block_addr(OUTLATCH_BASE, 3'($urandom)), 8'h00, 1'b1, "prdata_o latch");
         read_check(block_addr(STEERCLR_BASE, 3'($urandom)), 8'h00, 1'b1, "prdata_o steer");
         write_check(block_addr(SWITCH_BASE, 3'($urandom)), 8'($urandom), 1'b1);
         write_check(block_addr(INPUT_BASE, 3'($urandom)), 8'($urandom), 1'b1);
      end
      check_outputs();
      check_axes();

      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* sources.f */
common/centipede_io_pkg.sv
source/io_addr_decode.sv
trakball/trakball_input_select.sv
trakball/trakball_axis_counter.sv
source/io_read_mux.sv
source/coin_led_latch.sv
source/centipede_io_top.sv
tests/centipede_io_assertions.sv
tests/centipede_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sources.f --top-module centipede_io_tb \
   -o centipede_io_sim

status=0
./obj_dir/centipede_io_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TESTBENCH FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"
